// ==== Makefile ====
VERILATOR := verilator
TOP       := cp0_tb
FILELIST  := build.f
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := NO ERRORS

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
cp0_pkg.sv
cp0_wr_if.sv
cp0_ctrl.sv
cp0_timer.sv
cp0_exc_regs.sv
cp0_top.sv
cp0_sva.sv
cp0_tb.sv

// ==== cp0_ctrl.sv ====
`timescale 1ns/100ps

module cp0_ctrl (
    input  logic              clk,
    input  logic              resetn,
    input  logic [4:0]        idx,
    input  cp0_pkg::word_t    wdata,
    input  logic              wr,
    input  logic              exception,
    input  logic              bad_addr_valid,
    input  cp0_pkg::word_t    bad_addr,
    input  cp0_pkg::word_t    exc_pc,
    input  logic              in_delay_slot,
    input  logic [4:0]        exc_code,
    input  logic              eret,
    input  cp0_pkg::word_t    count,
    input  cp0_pkg::word_t    compare,
    input  cp0_pkg::status_t  status,
    input  cp0_pkg::cause_t   cause,
    input  cp0_pkg::word_t    epc_val,
    input  cp0_pkg::word_t    badvaddr,
    output cp0_pkg::word_t    rdata,
    cp0_wr_if.ctrl            wr_port
);
    import cp0_pkg::*;

    logic  sw_write;
    logic  compare_armed;
    word_t status_word;
    word_t cause_word;

    // eret beats exception beats software write
    assign wr_port.eret_take   = eret;
    assign wr_port.exc_take    = exception & ~eret;
    assign sw_write            = wr & ~eret & ~exception;
    assign wr_port.exc_badaddr = wr_port.exc_take & bad_addr_valid;

    // index decode, BadVAddr and unused indices are read only
    assign wr_port.we_count   = sw_write & (idx == idx_count);
    assign wr_port.we_compare = sw_write & (idx == idx_compare);
    assign wr_port.we_status  = sw_write & (idx == idx_status);
    assign wr_port.we_cause   = sw_write & (idx == idx_cause);
    assign wr_port.we_epc     = sw_write & (idx == idx_epc);

    assign wr_port.wdata    = wdata;
    assign wr_port.bad_addr = bad_addr;
    assign wr_port.exc_code = exc_code;

    // return to the branch when the fault sits in its delay slot
    assign wr_port.exc_pc = in_delay_slot ? exc_pc - 32'd4 : exc_pc;
    assign wr_port.bd     = in_delay_slot;

    // set once by the first Compare write after reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            compare_armed <= 1'b0;
        end else if (wr_port.we_compare) begin
            compare_armed <= 1'b1;
        end
    end

    // BEV stays at 1
    assign status_word = {
        9'b0, 1'b1, 6'b0, status.im, 6'b0, status.exl, status.ie
    };

    assign cause_word = {
        cause.bd, 15'b0, cause.ip, 1'b0, cause.exc_code, 2'b0
    };

    always_comb begin
        case (idx)
            idx_badvaddr: begin
                rdata = badvaddr;
            end
            idx_count: begin
                rdata = count;
            end
            idx_compare: begin
                // unprogrammed compare reads as zero
                rdata = compare_armed ? compare : '0;
            end
            idx_status: begin
                rdata = status_word;
            end
            idx_cause: begin
                rdata = cause_word;
            end
            idx_epc: begin
                rdata = epc_val;
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

endmodule

// ==== cp0_exc_regs.sv ====
`timescale 1ns/100ps

module cp0_exc_regs (
    input  logic             clk,
    input  logic             resetn,
    input  logic [5:0]       ext_int,
    input  logic             timer_pending,
    output cp0_pkg::status_t status,
    output cp0_pkg::cause_t  cause,
    output cp0_pkg::word_t   epc,
    output cp0_pkg::word_t   badvaddr,
    output logic             interrupt,
    cp0_wr_if.regs           wr_port
);
    import cp0_pkg::*;

    logic [5:0] hw_ip;
    logic [7:0] pending;
    logic [1:0] sw_ip_next;
    logic       first_exc;

    // timer shares IP7 with the top external line
    assign hw_ip = {ext_int[5] | timer_pending, ext_int[4:0]};

    assign pending   = {hw_ip, cause.ip[1:0]} & status.im;
    assign interrupt = (|pending) & status.ie & ~status.exl;

    assign sw_ip_next = wr_port.we_cause ? wr_port.wdata.ca.sw_ip : cause.ip[1:0];

    // nested exceptions keep EPC, BD and EXL
    assign first_exc = wr_port.exc_take & ~status.exl;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            status <= status_reset;
        end else if (wr_port.eret_take) begin
            status.exl <= 1'b0;
        end else if (wr_port.exc_take) begin
            status.exl <= 1'b1;
        end else if (wr_port.we_status) begin
            status.im  <= wr_port.wdata.st.im;
            status.exl <= wr_port.wdata.st.exl;
            status.ie  <= wr_port.wdata.st.ie;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cause <= '0;
        end else begin
            // hardware bits follow the masked lines every cycle
            cause.ip <= {pending[7:2], sw_ip_next};
            if (wr_port.exc_take) begin
                cause.exc_code <= wr_port.exc_code;
            end
            if (first_exc) begin
                cause.bd <= wr_port.bd;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            epc <= '0;
        end else if (first_exc) begin
            epc <= wr_port.exc_pc;
        end else if (wr_port.we_epc) begin
            epc <= wr_port.wdata;
        end
    end

    // software cannot write BadVAddr
    always_ff @(posedge clk) begin
        if (!resetn) begin
            badvaddr <= '0;
        end else if (wr_port.exc_take && wr_port.exc_badaddr) begin
            badvaddr <= wr_port.bad_addr;
        end
    end

endmodule

// ==== cp0_pkg.sv ====
package cp0_pkg;

    typedef logic [31:0] word_t;

    // register indices, select field ignored
    localparam logic [4:0] idx_badvaddr = 5'd8;
    localparam logic [4:0] idx_count    = 5'd9;
    localparam logic [4:0] idx_compare  = 5'd11;
    localparam logic [4:0] idx_status   = 5'd12;
    localparam logic [4:0] idx_cause    = 5'd13;
    localparam logic [4:0] idx_epc      = 5'd14;

    // exception codes as found in Cause.ExcCode
    localparam logic [4:0] exc_int  = 5'h00;
    localparam logic [4:0] exc_adel = 5'h04;
    localparam logic [4:0] exc_ades = 5'h05;
    localparam logic [4:0] exc_sys  = 5'h08;
    localparam logic [4:0] exc_bp   = 5'h09;
    localparam logic [4:0] exc_ri   = 5'h0a;
    localparam logic [4:0] exc_ov   = 5'h0c;

    // stored status fields
    typedef struct packed {
        logic [7:0] im;
        logic       exl;
        logic       ie;
    } status_t;

    // stored cause fields, IP7..2 hardware, IP1..0 software
    typedef struct packed {
        logic       bd;
        logic [7:0] ip;
        logic [4:0] exc_code;
    } cause_t;

    // software write word seen as a Status write
    typedef struct packed {
        logic [15:0] rsvd_hi;
        logic [7:0]  im;
        logic [5:0]  rsvd_lo;
        logic        exl;
        logic        ie;
    } status_view_t;

    // software write word seen as a Cause write
    typedef struct packed {
        logic [21:0] rsvd_hi;
        logic [1:0]  sw_ip;
        logic [7:0]  rsvd_lo;
    } cause_view_t;

    typedef union packed {
        status_view_t st;
        cause_view_t  ca;
    } cp0_wdata_u;

    localparam status_t status_reset = '{im: 8'h00, exl: 1'b0, ie: 1'b1};

endpackage

// ==== cp0_sva.sv ====
`timescale 1ns/100ps

module cp0_sva (
    input logic             clk,
    input logic             resetn,
    input logic             eret,
    input logic             interrupt,
    input cp0_pkg::status_t status,
    input logic [6:0]       strobes
);

    // five write enables plus the exception and eret strobes
    a_one_hot: assert property (@(posedge clk) disable iff (!resetn) $onehot0(strobes))
        else $error("more than one CP0 write strobe active in a cycle");

    a_eret_exl: assert property (@(posedge clk) disable iff (!resetn) eret |=> !status.exl)
        else $error("EXL still set one cycle after ERET");

    a_int_gate: assert property (
        @(posedge clk) disable iff (!resetn) (status.exl || !status.ie) |-> !interrupt
    ) else $error("interrupt raised while EXL is set or IE is clear");

endmodule

bind cp0_top cp0_sva cp0_sva_i (
    .clk       (clk),
    .resetn    (resetn),
    .eret      (eret),
    .interrupt (interrupt),
    .status    (status),
    .strobes   ({wr_bus.we_count, wr_bus.we_compare, wr_bus.we_status, wr_bus.we_cause,
                 wr_bus.we_epc, wr_bus.exc_take, wr_bus.eret_take})
);

// ==== cp0_tb.sv ====
`timescale 1ns/100ps

module cp0_tb;
    import cp0_pkg::*;

    logic       clk;
    logic       resetn;
    logic [4:0] idx;
    logic [4:0] exc_code;
    logic [5:0] ext_int;
    logic       wr, exception, bad_addr_valid, in_delay_slot, eret, interrupt;
    word_t      wdata, bad_addr, exc_pc, rdata, epc;
    word_t      rnd;

    // shadow copy of the CP0 state
    word_t      m_count, m_compare, m_epc, m_badvaddr;
    logic [7:0] m_im;
    logic [5:0] m_hw_ip;
    logic [4:0] m_code;
    logic [1:0] m_sw_ip;
    logic       m_exl, m_ie, m_bd, m_armed, m_tpend, m_phase;

    cp0_top cp0_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t ref_read(input logic [4:0] i);
        case (i)
            idx_badvaddr: return m_badvaddr;
            idx_count:    return m_count;
            idx_compare:  return m_armed ? m_compare : 32'h0;
            idx_status:   return {9'h0, 1'b1, 6'h0, m_im, 6'h0, m_exl, m_ie};
            idx_cause:    return {m_bd, 15'h0, m_hw_ip, m_sw_ip, 1'b0, m_code, 2'b0};
            idx_epc:      return m_epc;
            default:      return 32'h0;
        endcase
    endfunction

    function automatic logic ref_interrupt();
        logic [7:0] lines;
        lines = {ext_int[5] | m_tpend, ext_int[4:0], m_sw_ip};
        return (|(lines & m_im)) & m_ie & ~m_exl;
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value check failed");
        end
    endtask

    // eret beats exception beats write in the shadow model
    always @(posedge clk) begin
        logic sw;
        logic first;
        sw    = wr & ~eret & ~exception;
        first = exception & ~eret & ~m_exl;
        if (!resetn) begin
            {m_count, m_compare, m_epc, m_badvaddr} = '0;
            {m_im, m_hw_ip, m_code, m_sw_ip, m_exl, m_bd, m_armed, m_tpend, m_phase} = '0;
            m_ie = 1'b1;
        end else begin
            m_hw_ip = {ext_int[5] | m_tpend, ext_int[4:0]} & m_im[7:2];
            if (sw && idx == idx_cause)
                m_sw_ip = wdata[9:8];
            if (sw && idx == idx_compare) begin
                m_tpend   = (m_count == wdata);
                m_compare = wdata;
                m_armed   = 1'b1;
            end else if (m_armed && m_count == m_compare) begin
                m_tpend = 1'b1;
            end
            if (sw && idx == idx_count)
                m_count = wdata;
            else if (m_phase)
                m_count = m_count + 32'd1;
            m_phase = ~m_phase;
            if (exception && !eret) begin
                m_code = exc_code;
                if (bad_addr_valid)
                    m_badvaddr = bad_addr;
            end
            if (first) begin
                m_bd  = in_delay_slot;
                m_epc = in_delay_slot ? exc_pc - 32'd4 : exc_pc;
                m_exl = 1'b1;
            end
            if (eret)
                m_exl = 1'b0;
            if (sw && idx == idx_status)
                {m_im, m_exl, m_ie} = {wdata[15:8], wdata[1:0]};
            if (sw && idx == idx_epc)
                m_epc = wdata;
        end
    end

    always @(posedge clk) begin
        #5;
        check("rdata", rdata, ref_read(idx));
        check("epc", epc, m_epc);
        check("interrupt", {31'h0, interrupt}, {31'h0, ref_interrupt()});
    end

    task automatic write_reg(input logic [4:0] i, input word_t d);
        @(negedge clk);
        idx   = i;
        wdata = d;
        wr    = 1'b1;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic raise_exception();
        @(negedge clk);
        rnd            = $urandom();
        exception      = 1'b1;
        exc_pc         = $urandom() & 32'hffff_fffc;
        bad_addr       = $urandom();
        exc_code       = rnd[4:0];
        bad_addr_valid = rnd[5];
        in_delay_slot  = rnd[6];
        @(negedge clk);
        exception = 1'b0;
    endtask

    // optionally collide with an exception and a Status write
    task automatic pulse_eret(input logic with_others);
        @(negedge clk);
        eret      = 1'b1;
        exception = with_others;
        wr        = with_others;
        idx       = idx_status;
        wdata     = $urandom();
        @(negedge clk);
        {eret, exception, wr} = 3'b000;
    endtask

    task automatic read_sweep();
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            idx = i[4:0];
        end
    endtask

    task automatic wait_for_interrupt(input int limit);
        int n;
        n = 0;
        while (interrupt !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("timeout: timer interrupt never asserted");
                $display("ERRORS FOUND");
                $fatal(1, "timeout");
            end
        end
    endtask

    initial begin
        word_t v;
        word_t k;
        rnd = $urandom(32'h3a17);
        {resetn, wr, exception, bad_addr_valid, in_delay_slot, eret} = '0;
        {idx, exc_code, ext_int} = '0;
        {wdata, bad_addr, exc_pc} = '0;
        repeat (2) @(negedge clk);
        resetn = 1'b1;
        read_sweep();
        // random index in 8..15 also hits BadVAddr and unused slots
        repeat (30) begin
            rnd = $urandom();
            write_reg(5'd8 + {2'b0, rnd[2:0]}, $urandom());
        end
        repeat (4) begin
            v = $urandom();
            k = 32'd1 + ($urandom() % 32'd8);
            write_reg(idx_count, v);
            repeat (2 * k) @(negedge clk);
            check("count", rdata, v + k);
        end
        write_reg(idx_status, 32'h0000_0001);
        repeat (6) begin
            raise_exception();
            read_sweep();
            raise_exception();
            read_sweep();
            pulse_eret(1'b0);
            raise_exception();
            pulse_eret(1'b1);
            read_sweep();
        end
        repeat (40) begin
            rnd = $urandom();
            write_reg(idx_status, {16'h0, rnd[15:8], 6'h0, rnd[1:0]});
            write_reg(idx_cause, {22'h0, rnd[17:16], 8'h0});
            @(negedge clk);
            ext_int = rnd[23:18];
            @(negedge clk);
            idx = idx_cause;
        end
        // timer match through IM7
        ext_int = 6'h0;
        write_reg(idx_cause, 32'h0);
        write_reg(idx_status, 32'h0000_8001);
        write_reg(idx_compare, m_count + 32'd4);
        idx = idx_cause;
        wait_for_interrupt(40);
        repeat (2) @(negedge clk);
        check("cause.ip7", {31'h0, rdata[15]}, 32'h1);
        write_reg(idx_compare, m_count + 32'd100);
        check("interrupt", {31'h0, interrupt}, 32'h0);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== cp0_timer.sv ====
`timescale 1ns/100ps

module cp0_timer #(
    parameter int count_div_log2 = 1
) (
    input  logic           clk,
    input  logic           resetn,
    output cp0_pkg::word_t count,
    output cp0_pkg::word_t compare,
    output logic           timer_pending,
    cp0_wr_if.regs         wr_port
);

    logic [count_div_log2-1:0] div_cnt;
    logic                      tick;
    logic                      armed;
    logic                      count_match;
    logic                      new_match;

    // free running, count writes leave it alone
    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign tick = &div_cnt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
        end else if (wr_port.we_count) begin
            count <= wr_port.wdata;
        end else if (tick) begin
            count <= count + 32'd1;
        end
    end

    assign count_match = armed & (count == compare);
    assign new_match   = (count == wr_port.wdata);

    // writing compare acks the pending interrupt
    always_ff @(posedge clk) begin
        if (!resetn) begin
            compare       <= '0;
            armed         <= 1'b0;
            timer_pending <= 1'b0;
        end else if (wr_port.we_compare) begin
            compare       <= wr_port.wdata;
            armed         <= 1'b1;
            timer_pending <= new_match;
        end else if (count_match) begin
            timer_pending <= 1'b1;
        end
    end

endmodule

// ==== cp0_top.sv ====
`timescale 1ns/100ps

module cp0_top #(
    parameter int count_div_log2 = 1
) (
    input  logic           clk,
    input  logic           resetn,
    input  logic [4:0]     idx,
    input  cp0_pkg::word_t wdata,
    input  logic           wr,
    input  logic           exception,
    input  logic           bad_addr_valid,
    input  cp0_pkg::word_t bad_addr,
    input  cp0_pkg::word_t exc_pc,
    input  logic           in_delay_slot,
    input  logic [4:0]     exc_code,
    input  logic           eret,
    input  logic [5:0]     ext_int,
    output cp0_pkg::word_t rdata,
    output cp0_pkg::word_t epc,
    output logic           interrupt
);
    import cp0_pkg::*;

    word_t   count;
    word_t   compare;
    word_t   badvaddr;
    logic    timer_pending;
    status_t status;
    cause_t  cause;

    cp0_wr_if wr_bus ();

    cp0_ctrl cp0_ctrl_i (
        .clk            (clk),
        .resetn         (resetn),
        .idx            (idx),
        .wdata          (wdata),
        .wr             (wr),
        .exception      (exception),
        .bad_addr_valid (bad_addr_valid),
        .bad_addr       (bad_addr),
        .exc_pc         (exc_pc),
        .in_delay_slot  (in_delay_slot),
        .exc_code       (exc_code),
        .eret           (eret),
        .count          (count),
        .compare        (compare),
        .status         (status),
        .cause          (cause),
        .epc_val        (epc),
        .badvaddr       (badvaddr),
        .rdata          (rdata),
        .wr_port        (wr_bus.ctrl)
    );

    cp0_timer #(
        .count_div_log2 (count_div_log2)
    ) cp0_timer_i (
        .clk           (clk),
        .resetn        (resetn),
        .count         (count),
        .compare       (compare),
        .timer_pending (timer_pending),
        .wr_port       (wr_bus.regs)
    );

    cp0_exc_regs cp0_exc_regs_i (
        .clk           (clk),
        .resetn        (resetn),
        .ext_int       (ext_int),
        .timer_pending (timer_pending),
        .status        (status),
        .cause         (cause),
        .epc           (epc),
        .badvaddr      (badvaddr),
        .interrupt     (interrupt),
        .wr_port       (wr_bus.regs)
    );

endmodule

// ==== cp0_wr_if.sv ====
`timescale 1ns/100ps

interface cp0_wr_if;
    import cp0_pkg::*;

    // payload
    cp0_wdata_u  wdata;
    word_t       exc_pc;
    word_t       bad_addr;
    logic [4:0]  exc_code;
    logic        bd;

    // one-cycle strobes, at most one group active
    logic we_count;
    logic we_compare;
    logic we_status;
    logic we_cause;
    logic we_epc;
    logic exc_take;
    logic exc_badaddr;
    logic eret_take;

    modport ctrl (
        output wdata, exc_pc, bad_addr, exc_code, bd,
        output we_count, we_compare, we_status, we_cause, we_epc,
        output exc_take, exc_badaddr, eret_take
    );

    modport regs (
        input wdata, exc_pc, bad_addr, exc_code, bd,
        input we_count, we_compare, we_status, we_cause, we_epc,
        input exc_take, exc_badaddr, eret_take
    );

endinterface
